// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = ram512k_tb
FLIST = ram512k_top.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== logic/bus_cycle_fsm.sv ====
//####################
// classifies host bus cycles on the card clock
// gives the bank load pulse and the memory write level
//####################

module bus_cycle_fsm
   import ram512k_bus_pkg::*;
(
   input  logic     clk,
   input  logic     reset_b,
   input  logic     iorq_b,
   input  logic     mreq_b,
   input  logic     wr_b,
   input  logic     rd_b,
   input  logic     adr15,
   input  sel_cmd_t data,
   output logic     bank_load, // one clock pulse before the register load
   output logic     wr_cycle   // high for the whole memory write
);

   bus_state_t state_q;
   bus_state_t state_d;
   logic       sel_match; // io write that addresses the card

   // any port with adr15 low and both tag bits set
   assign sel_match = !iorq_b && !wr_b && !adr15 &&
                      (data[SEL_TAG_LSB +: 2] == SEL_TAG);

   always_comb
   begin
      state_d = state_q; // hold by default
      case (state_q)
         st_idle:
         begin
            if (sel_match)
            begin
               state_d = st_io_wr;
            end
            else if (!iorq_b)
            begin
               state_d = st_wait_end; // other io just passes
            end
            else if (!mreq_b && !wr_b)
            begin
               state_d = st_mem_wr;
            end
            else if (!mreq_b && !rd_b)
            begin
               state_d = st_mem_rd;
            end
         end
         st_io_wr:
         begin
            state_d = st_wait_end; // only one load per io cycle
         end
         st_mem_rd:
         begin
            if (mreq_b)
            begin
               state_d = st_idle;
            end
         end
         st_mem_wr:
         begin
            if (mreq_b)
            begin
               state_d = st_idle; // write level ends at this edge
            end
         end
         st_wait_end:
         begin
            if (iorq_b)
            begin
               state_d = st_idle;
            end
         end
         default:
         begin
            state_d = st_idle; // recover from an unused encoding
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         state_q <= st_idle;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // both outputs decode straight from the state register
   assign bank_load = (state_q == st_io_wr);
   assign wr_cycle  = (state_q == st_mem_wr);

   // one load per io cycle since iorq_b was high before the select was seen
   a_load_single : assert property (
      @(posedge clk) disable iff (!reset_b)
      bank_load |-> $past(iorq_b, 2)
   );

   // write level only while mreq_b stays low and never together with a load
   a_load_not_in_write : assert property (
      @(posedge clk) disable iff (!reset_b)
      wr_cycle |-> !$past(mreq_b) && !bank_load
   );

endmodule

// ==== logic/ram512k_bus_pkg.sv ====
//####################
// host bus cycle types for the 512K RAM card
// imported by the cycle FSM, the mapper and the top level
//####################

package ram512k_bus_pkg;

   // cycle states, one per kind of host bus cycle
   typedef enum logic [2:0]
   {
      st_idle     = 3'd0, // waiting for a new cycle
      st_io_wr    = 3'd1, // bank-select write seen, load pulse cycle
      st_mem_rd   = 3'd2, // memory read in progress
      st_mem_wr   = 3'd3, // memory write in progress
      st_wait_end = 3'd4  // io cycle running out, wait for iorq_b high
   } bus_state_t;

   // data byte of a bank-select write, 11 bbb sss
   typedef logic [7:0] sel_cmd_t;

   // field positions inside sel_cmd_t
   localparam int SEL_SCHEME_LSB = 0; // block-switching scheme
   localparam int SEL_BANK_LSB   = 3; // 64K bank number
   localparam int SEL_TAG_LSB    = 6; // two tag bits

   // both tag bits set marks a valid select
   localparam logic [1:0] SEL_TAG = 2'b11;

endpackage

// ==== logic/ram512k_map_pkg.sv ====
//####################
// RAM mapping types and the bank alias rule
// shared by the bank mapper and the checker model
//####################

package ram512k_map_pkg;

   typedef logic [2:0] bank_t;   // 64K bank number
   typedef logic [2:0] scheme_t; // block-switching scheme
   typedef logic [1:0] block_t;  // 16K block, same as host adr15:adr14
   typedef logic [4:0] ram_hi_t; // RAM high address, bank then block

   // only bank 2 is fitted of the pair, bank 3 lands on it
   localparam bank_t ALIAS_SRC = 3'd3;
   localparam bank_t ALIAS_DST = 3'd2;

   // blocks that the switching schemes treat specially
   localparam block_t BLK_TOP = 2'd3; // 0xc000-0xffff
   localparam block_t BLK_WIN = 2'd1; // 0x4000-0x7fff window

   // apply the alias rule to a selected bank
   function automatic bank_t alias_bank(input bank_t bank);
      bank_t result;
      if (bank == ALIAS_SRC)
      begin
         result = ALIAS_DST; // folded onto the fitted bank
      end
      else
      begin
         result = bank;
      end
      return result;
   endfunction

endpackage

// ==== logic/ram512k_top.sv ====
//####################
// top level of the 512K RAM expansion card logic
// set DEFAULT_BANK and WE_DELAY here, they go down to the blocks
//####################

module ram512k_top
   import ram512k_bus_pkg::*;
   import ram512k_map_pkg::*;
#(
   parameter bank_t DEFAULT_BANK = 3'd3, // bank for default accesses
   parameter int    WE_DELAY     = 2     // write strobe delay in clocks
)
(
   input  logic     clk,
   input  logic     reset_b,
   input  logic     adr15,
   input  logic     adr14,
   input  logic     iorq_b,
   input  logic     mreq_b,
   input  logic     wr_b,
   input  logic     rd_b,
   input  logic     ramrd_b,
   input  sel_cmd_t data,
   input  logic     mode464,
   output logic     ramdis,
   output logic     ramcs_b,
   output ram_hi_t  ramadrhi,
   output logic     ramoe_b,
   output logic     ramwe_b
);

   logic bank_load; // FSM to mapper
   logic wr_cycle;  // FSM to strobe timer

   bus_cycle_fsm i_bus_cycle_fsm (
      .clk       (clk),
      .reset_b   (reset_b),
      .iorq_b    (iorq_b),
      .mreq_b    (mreq_b),
      .wr_b      (wr_b),
      .rd_b      (rd_b),
      .adr15     (adr15),
      .data      (data),
      .bank_load (bank_load),
      .wr_cycle  (wr_cycle)
   );

   we_strobe_timer #(
      .WE_DELAY (WE_DELAY)
   ) i_we_strobe_timer (
      .clk      (clk),
      .reset_b  (reset_b),
      .wr_cycle (wr_cycle),
      .ramwe_b  (ramwe_b)
   );

   ram_bank_mapper #(
      .DEFAULT_BANK (DEFAULT_BANK)
   ) i_ram_bank_mapper (
      .clk       (clk),
      .reset_b   (reset_b),
      .bank_load (bank_load),
      .data      (data),
      .adr15     (adr15),
      .adr14     (adr14),
      .mreq_b    (mreq_b),
      .ramrd_b   (ramrd_b),
      .mode464   (mode464),
      .ramadrhi  (ramadrhi),
      .ramcs_b   (ramcs_b),
      .ramdis    (ramdis),
      .ramoe_b   (ramoe_b)
   );

endmodule

// ==== logic/ram_bank_mapper.sv ====
//####################
// bank-select register and block mapping for every memory access
// drives RAM high address, chip select, ramdis and output enable
//####################

module ram_bank_mapper
   import ram512k_bus_pkg::*;
   import ram512k_map_pkg::*;
#(
   parameter bank_t DEFAULT_BANK = 3'd3 // bank standing in for internal RAM
)
(
   input  logic     clk,
   input  logic     reset_b,
   input  logic     bank_load,
   input  sel_cmd_t data,
   input  logic     adr15,
   input  logic     adr14,
   input  logic     mreq_b,
   input  logic     ramrd_b,
   input  logic     mode464,
   output ram_hi_t  ramadrhi,
   output logic     ramcs_b,
   output logic     ramdis,
   output logic     ramoe_b
);

   bank_t   bank_q;   // selected 64K bank
   scheme_t scheme_q; // selected switching scheme
   bank_t   bank_al;  // bank after the alias rule
   block_t  blk;      // block addressed by the host
   ram_hi_t hi;
   logic    exp_sel;  // access goes to the expansion RAM

   // capture the select byte on the load pulse
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         bank_q   <= '0;
         scheme_q <= '0;
      end
      else if (bank_load)
      begin
         bank_q   <= data[SEL_BANK_LSB +: $bits(bank_t)];
         scheme_q <= data[SEL_SCHEME_LSB +: $bits(scheme_t)];
      end
   end

   assign bank_al = alias_bank(bank_q);
   assign blk     = {adr15, adr14};

   always_comb
   begin
      hi      = {DEFAULT_BANK, blk}; // default bank, block as addressed
      exp_sel = mode464;             // default bank only used when enabled
      case (scheme_q)
         3'd0:
         begin
            hi      = {DEFAULT_BANK, blk}; // plain, nothing switched
            exp_sel = mode464;
         end
         3'd1:
         begin
            if (blk == BLK_TOP)
            begin
               hi      = {bank_al, BLK_TOP}; // top block swapped
               exp_sel = 1'b1;
            end
         end
         3'd2:
         begin
            hi      = {bank_al, blk}; // whole 64K replaced
            exp_sel = 1'b1;
         end
         3'd3:
         begin
            if (blk == BLK_TOP)
            begin
               hi      = {bank_al, BLK_TOP};
               exp_sel = 1'b1;
            end
            else if (blk != 2'd0)
            begin
               hi = {DEFAULT_BANK, BLK_TOP}; // blocks 1 and 2 fold onto block 3
            end
         end
         default:
         begin
            // schemes 4 to 7, any block of the bank through the 0x4000 window
            if (blk == BLK_WIN)
            begin
               hi      = {bank_al, scheme_q[1:0]};
               exp_sel = 1'b1;
            end
         end
      endcase
   end

   assign ramadrhi = hi;
   assign ramdis   = exp_sel;             // internal RAM off when expansion used
   assign ramcs_b  = !(exp_sel && !mreq_b); // chip only during memory cycles
   assign ramoe_b  = ramrd_b;             // host RAM read gives the output enable

endmodule

// ==== logic/we_strobe_timer.sv ====
//####################
// delays the RAM write enable into a memory write cycle
// WE_DELAY clocks after wr_cycle rises, released when it falls
//####################

module we_strobe_timer #(
   parameter int WE_DELAY = 2 // clocks to ramwe_b low, 1 to 7
)
(
   input  logic clk,
   input  logic reset_b,
   input  logic wr_cycle,
   output logic ramwe_b
);

   // count reaches this one edge before the strobe turns on
   localparam logic [2:0] WE_THRESH = 3'(WE_DELAY - 1);

   logic [2:0] count_q; // clocks spent inside the write cycle
   logic       we_on_q; // strobe armed

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         count_q <= '0;
         we_on_q <= 1'b0;
      end
      else if (!wr_cycle)
      begin
         count_q <= '0; // ready for the next write
         we_on_q <= 1'b0;
      end
      else
      begin
         if (count_q != 3'd7)
         begin
            count_q <= count_q + 3'd1; // saturate, long cycles keep the strobe on
         end
         we_on_q <= (count_q >= WE_THRESH);
      end
   end

   // address and data have settled by the time the strobe is armed,
   // and the strobe lets go with the write level so it ends on the mreq_b edge
   assign ramwe_b = !(we_on_q && wr_cycle);

   // the strobe may only fall WE_DELAY clocks into a write cycle
   a_we_timing : assert property (
      @(posedge clk) disable iff (!reset_b)
      $fell(ramwe_b) |-> $past(wr_cycle, WE_DELAY) && !$past(wr_cycle, WE_DELAY + 1)
   );

endmodule

// ==== ram512k_top.f ====
logic/ram512k_bus_pkg.sv
logic/ram512k_map_pkg.sv
logic/bus_cycle_fsm.sv
logic/we_strobe_timer.sv
logic/ram_bank_mapper.sv
logic/ram512k_top.sv
verification/ram512k_checker.sv
verification/ram512k_tb.sv

// ==== verification/ram512k_checker.sv ====
//####################
// reference model of the card, compared with the DUT each negedge
// instanced next to the DUT in the testbench top
//####################

module ram512k_checker
   import ram512k_bus_pkg::*;
   import ram512k_map_pkg::*;
#(
   parameter bank_t DEFAULT_BANK = 3'd3,
   parameter int    WE_DELAY     = 2
)
(
   input  logic     clk,
   input  logic     reset_b,
   input  logic     adr15,
   input  logic     adr14,
   input  logic     iorq_b,
   input  logic     mreq_b,
   input  logic     wr_b,
   input  logic     rd_b,
   input  logic     ramrd_b,
   input  sel_cmd_t data,
   input  logic     mode464,
   input  logic     ramdis,
   input  logic     ramcs_b,
   input  ram_hi_t  ramadrhi,
   input  logic     ramoe_b,
   input  logic     ramwe_b,
   output int       error_count,
   output int       check_count
);

   timeunit 1ns;
   timeprecision 100ps;

   typedef enum logic [2:0] {mdl_idle, mdl_load, mdl_io, mdl_rd, mdl_wr} model_state_t;

   model_state_t m_state;
   bank_t        m_bank;
   scheme_t      m_scheme;
   int           m_wr_clocks; // edges since the write cycle began
   int           errors = 0;
   int           checks = 0;

   assign error_count = errors;
   assign check_count = checks;

   // expected {expansion select, bank, block} for one access
   function automatic logic [5:0] map_access(input bank_t bank, input scheme_t scheme,
                                             input block_t blk, input logic m464);
      bank_t  b_al;
      bank_t  b_out;
      block_t k_out;
      logic   sel;
      b_al  = alias_bank(bank);
      b_out = DEFAULT_BANK; // internal RAM stand-in unless switched
      k_out = blk;
      sel   = m464;
      if (scheme == 3'd2)
      begin
         b_out = b_al;
         sel   = 1'b1;
      end
      else if (scheme == 3'd1 || scheme == 3'd3)
      begin
         if (blk == 2'd3)
         begin
            b_out = b_al;
            sel   = 1'b1;
         end
         else if (scheme == 3'd3 && blk != 2'd0)
         begin
            k_out = 2'd3; // blocks 1 and 2 seen as block 3
         end
      end
      else if (scheme[2])
      begin
         if (blk == 2'd1)
         begin
            b_out = b_al;
            k_out = scheme[1:0];
            sel   = 1'b1;
         end
      end
      return {sel, b_out, k_out};
   endfunction

   task automatic check_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
      end
   endtask

   // bus cycle tracking, bank register loads one edge after the select is seen
   always @(posedge clk)
   begin
      if (!reset_b)
      begin
         m_state     <= mdl_idle;
         m_bank      <= '0;
         m_scheme    <= '0;
         m_wr_clocks <= 0;
      end
      else
      begin
         case (m_state)
            mdl_idle:
            begin
               if (!iorq_b && !wr_b && !adr15 && data[7:6] == 2'b11)
               begin
                  m_state <= mdl_load;
               end
               else if (!iorq_b)
               begin
                  m_state <= mdl_io;
               end
               else if (!mreq_b && !wr_b)
               begin
                  m_state     <= mdl_wr;
                  m_wr_clocks <= 0;
               end
               else if (!mreq_b && !rd_b)
               begin
                  m_state <= mdl_rd;
               end
            end
            mdl_load:
            begin
               m_bank   <= data[5:3];
               m_scheme <= data[2:0];
               m_state  <= mdl_io;
            end
            mdl_io:
            begin
               if (iorq_b)
               begin
                  m_state <= mdl_idle;
               end
            end
            mdl_rd:
            begin
               if (mreq_b)
               begin
                  m_state <= mdl_idle;
               end
            end
            default:
            begin
               if (mreq_b)
               begin
                  m_state <= mdl_idle; // write over, strobe released here
               end
               else
               begin
                  m_wr_clocks <= m_wr_clocks + 1;
               end
            end
         endcase
      end
   end

   // outputs have settled half a clock after the edge
   always @(negedge clk)
   begin
      logic [5:0] exp_map;
      logic       exp_we_b;
      if (reset_b)
      begin
         exp_map  = map_access(m_bank, m_scheme, {adr15, adr14}, mode464);
         exp_we_b = !(m_state == mdl_wr && m_wr_clocks >= WE_DELAY);
         check_value("ramadrhi", 8'(exp_map[4:0]), 8'(ramadrhi));
         check_value("ramdis", 8'(exp_map[5]), 8'(ramdis));
         check_value("ramcs_b", 8'(!(exp_map[5] && !mreq_b)), 8'(ramcs_b));
         check_value("ramoe_b", 8'(ramrd_b), 8'(ramoe_b));
         check_value("ramwe_b", 8'(exp_we_b), 8'(ramwe_b));
      end
   end

endmodule

// ==== verification/ram512k_tb.sv ====
//####################
// testbench top for the 512K RAM card, random host bus cycles
// ram512k_checker watches the DUT, run it through the Makefile
//####################

module ram512k_tb
   import ram512k_bus_pkg::*;
   import ram512k_map_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam bank_t DEFAULT_BANK = 3'd3;
   localparam int    WE_DELAY     = 3;   // off the top default so the pass-down is exercised
   localparam int    CYCLE_NS     = 4;
   localparam int    RESET_CYCLES = 10;
   localparam int    N_OPS        = 400;
   // at most 7 clocks per operation, 10 leaves headroom
   localparam int    TIMEOUT_NS   = (N_OPS * 10 + RESET_CYCLES) * CYCLE_NS;

   logic     clk = 1'b0;
   logic     reset_b;
   logic     adr15;
   logic     adr14;
   logic     iorq_b;
   logic     mreq_b;
   logic     wr_b;
   logic     rd_b;
   logic     ramrd_b;
   sel_cmd_t data;
   logic     mode464;
   logic     ramdis;
   logic     ramcs_b;
   ram_hi_t  ramadrhi;
   logic     ramoe_b;
   logic     ramwe_b;
   int       error_count;  // from the checker
   int       check_count;
   integer   seed = 95930;

   always #(CYCLE_NS / 2) clk = ~clk;

   ram512k_top #(
      .DEFAULT_BANK (DEFAULT_BANK),
      .WE_DELAY     (WE_DELAY)
   ) i_dut (.*);

   ram512k_checker #(
      .DEFAULT_BANK (DEFAULT_BANK),
      .WE_DELAY     (WE_DELAY)
   ) i_checker (.*);

   // uniform pick in lo..hi from the seeded generator
   function automatic int rand_range(input int lo, input int hi);
      return lo + int'({$random(seed)} % (hi - lo + 1));
   endfunction

   task automatic next_drive();
      @(posedge clk);
      #1; // inputs change well away from the edge
   endtask

   // all strobes released, address keeps moving so the mapping is still exercised
   task automatic bus_idle();
      iorq_b  = 1'b1;
      mreq_b  = 1'b1;
      wr_b    = 1'b1;
      rd_b    = 1'b1;
      ramrd_b = 1'b1;
      adr15   = 1'(rand_range(0, 1));
      adr14   = 1'(rand_range(0, 1));
   endtask

   // kind 0 select write, 1 io write the card ignores, 2 memory read, 3 memory write
   task automatic start_op(input int kind);
      bank_t   bnk;
      scheme_t sch;
      adr15 = 1'(rand_range(0, 1));
      adr14 = 1'(rand_range(0, 1));
      data  = sel_cmd_t'(rand_range(0, 255));
      case (kind)
         0:
         begin
            bnk    = bank_t'(rand_range(0, 7));
            sch    = scheme_t'(rand_range(0, 7));
            adr15  = 1'b0;
            data   = {SEL_TAG, bnk, sch};
            iorq_b = 1'b0;
            wr_b   = 1'b0;
         end
         1:
         begin
            if (rand_range(0, 1) == 1)
            begin
               adr15     = 1'b1;    // right tag, wrong port
               data[7:6] = SEL_TAG;
            end
            else
            begin
               adr15     = 1'b0;
               data[7:6] = 2'(rand_range(0, 2)); // tag with a bit clear
            end
            iorq_b = 1'b0;
            wr_b   = 1'b0;
         end
         2:
         begin
            mreq_b  = 1'b0;
            rd_b    = 1'b0;
            ramrd_b = 1'b0;
         end
         default:
         begin
            mreq_b = 1'b0;
            wr_b   = 1'b0;
         end
      endcase
   endtask

   initial
   begin
      #(TIMEOUT_NS);
      $display("timeout: bus stimulus did not finish within %0d ns", TIMEOUT_NS);
      $display("checks %0d, errors %0d", check_count, error_count);
      $display("Regression failed");
      $finish;
   end

   initial
   begin
      int kind;
      int len;
      reset_b = 1'b0;
      mode464 = 1'b0;
      data    = '0;
      bus_idle();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset_b = 1'b1;
      for (int i = 0; i < N_OPS; i++)
      begin
         if (rand_range(0, 1) == 1)
         begin
            mode464 = !mode464;
         end
         // first ops run on the reset mapping, no select yet
         kind = (i < 10) ? rand_range(1, 3) : rand_range(0, 3);
         len  = rand_range(3, 6);
         start_op(kind);
         repeat (len) next_drive();
         bus_idle(); // one clock gap so every cycle ends cleanly
         next_drive();
      end
      repeat (4) next_drive();
      @(negedge clk);
      #1; // last compare has run
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0 && check_count > 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         if (check_count == 0)
         begin
            $display("no output was ever compared");
         end
         $display("Regression failed");
      end
      $finish;
   end

endmodule
